// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath width and register file size
`define CPU_XLEN 32
`define CPU_NREGS 32
`define CPU_REG_ABITS $clog2(`CPU_NREGS)

// memory depths in words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 1024
`define CPU_IMEM_ABITS $clog2(`CPU_IMEM_WORDS)
`define CPU_DMEM_ABITS $clog2(`CPU_DMEM_WORDS)

// byte address into a data memory of 4-byte words
`define CPU_DADDR_BITS (`CPU_DMEM_ABITS + 2)

`define CPU_RESET_PC 32'h0000_0000

`endif

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef struct packed {
		logic       rsv;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] fill;
		logic [4:0] sub;
	} instr_t;

	// major opcodes in bits 30..25
	typedef enum logic [5:0] {
		OP_LWI     = 6'b000010,
		OP_SWI     = 6'b001010,
		OP_TY_LS   = 6'b011100,
		OP_TY_BASE = 6'b100000,
		OP_MOVI    = 6'b100010,
		OP_ADDI    = 6'b101000,
		OP_XORI    = 6'b101011,
		OP_ORI     = 6'b101100
	} opcode_e;

	typedef enum logic [4:0] {
		BS_ADD   = 5'b00000,
		BS_SUB   = 5'b00001,
		BS_AND   = 5'b00010,
		BS_XOR   = 5'b00011,
		BS_OR    = 5'b00100,
		BS_SLLI  = 5'b01000,
		BS_SRLI  = 5'b01001,
		BS_ROTRI = 5'b01011
	} base_sub_e;

	typedef enum logic [7:0] {
		LS_LW = 8'b0000_0010,
		LS_SW = 8'b0000_1010
	} ls_sub_e;

	// nine alu operations
	typedef enum logic [3:0] {
		ALU_PASS_B,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROTR
	} alu_op_e;

	typedef enum logic [1:0] {IMM_REG, IMM_5, IMM_15, IMM_20} imm_sel_e;
	typedef enum logic {EXT_SIGN, EXT_ZERO} imm_ext_e;
	typedef enum logic {ADDR_IMM, ADDR_REG} addr_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		imm_sel_e  imm_sel;
		imm_ext_e  imm_ext;
		addr_sel_e addr_sel;
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_read;
		logic      mem_write;
	} ctrl_t;

	typedef enum logic [1:0] {FETCH_REQ, FETCH_LATCH, EXECUTE, WRITEBACK} phase_e;

endpackage

`default_nettype wire

// File: sync_mem.sv
`timescale 1ns/1ps
`default_nettype none

module sync_mem #(
	parameter type word_t = logic [31:0],
	parameter int  depth  = 256
) (
	input  wire logic                     clock,
	input  wire logic [$clog2(depth)-1:0] addr,
	input  wire logic                     we,
	input  wire logic                     re,
	input  wire word_t                    wdata,
	output word_t                         rdata
);

	word_t mem [depth];

	// read data shows up the cycle after re
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		if (re) begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module regfile (
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic [`CPU_REG_ABITS-1:0] ra_addr,
	input  wire logic [`CPU_REG_ABITS-1:0] rb_addr,
	input  wire logic [`CPU_REG_ABITS-1:0] rt_addr,
	input  wire logic                      we,
	input  wire logic [`CPU_XLEN-1:0]      wd,
	output logic      [`CPU_XLEN-1:0]      ra_data,
	output logic      [`CPU_XLEN-1:0]      rb_data,
	output logic      [`CPU_XLEN-1:0]      rt_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	// r0 holds data like any other register
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rt_addr] <= wd;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	// store data comes from rt
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
	input  wire alu_op_e              op,
	input  wire logic [`CPU_XLEN-1:0] a,
	input  wire logic [`CPU_XLEN-1:0] b,
	output logic      [`CPU_XLEN-1:0] y
);

	logic [4:0]             shamt;
	logic [2*`CPU_XLEN-1:0] rot_wide;

	assign shamt = b[4:0];

	// rotate right by shifting a doubled word
	assign rot_wide = {a, a} >> shamt;

	always_comb begin
		case (op)
			ALU_ADD: begin
				y = a + b;
			end
			ALU_SUB: begin
				y = a - b;
			end
			ALU_AND: begin
				y = a & b;
			end
			ALU_OR: begin
				y = a | b;
			end
			ALU_XOR: begin
				y = a ^ b;
			end
			ALU_SRL: begin
				y = a >> shamt;
			end
			ALU_SLL: begin
				y = a << shamt;
			end
			ALU_ROTR: begin
				y = rot_wide[`CPU_XLEN-1:0];
			end
			default: begin
				// movi passes b straight through
				y = b;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller import cpu_pkg::*; (
	input  wire logic   clock,
	input  wire logic   reset,
	input  wire logic   hold,
	input  wire instr_t ir,
	output logic        im_read,
	output logic        ir_load,
	output logic        pc_advance,
	output logic        execute,
	output logic        writeback,
	output ctrl_t       ctrl
);

	phase_e phase;
	phase_e phase_next;
	logic   run;
	logic   active;
	logic [7:0] ls_sub;

	// one cycle of idle after reset or load before the first fetch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			run <= 1'b0;
		end else begin
			run <= !hold;
		end
	end

	always_comb begin
		case (phase)
			FETCH_REQ:   phase_next = FETCH_LATCH;
			FETCH_LATCH: phase_next = EXECUTE;
			EXECUTE:     phase_next = WRITEBACK;
			default:     phase_next = FETCH_REQ;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= FETCH_REQ;
		end else if (hold) begin
			phase <= FETCH_REQ;
		end else if (run) begin
			phase <= phase_next;
		end
	end

	assign active     = run && !hold;
	assign im_read    = active && (phase == FETCH_REQ);
	assign ir_load    = active && (phase == FETCH_LATCH);
	assign pc_advance = active && (phase == FETCH_LATCH);
	assign execute    = active && (phase == EXECUTE);
	assign writeback  = active && (phase == WRITEBACK);

	// load/store sub-opcode spans bits 7..0
	assign ls_sub = {ir.fill[2:0], ir.sub};

	always_comb begin
		ctrl = '{
			alu_op:     ALU_PASS_B,
			imm_sel:    IMM_REG,
			imm_ext:    EXT_SIGN,
			addr_sel:   ADDR_IMM,
			reg_write:  1'b0,
			mem_to_reg: 1'b0,
			mem_read:   1'b0,
			mem_write:  1'b0
		};
		case (ir.opcode)
			OP_TY_BASE: begin
				ctrl.reg_write = 1'b1;
				case (ir.sub)
					BS_ADD: ctrl.alu_op = ALU_ADD;
					BS_SUB: ctrl.alu_op = ALU_SUB;
					BS_AND: ctrl.alu_op = ALU_AND;
					BS_OR:  ctrl.alu_op = ALU_OR;
					BS_XOR: ctrl.alu_op = ALU_XOR;
					BS_SRLI: begin
						ctrl.alu_op  = ALU_SRL;
						ctrl.imm_sel = IMM_5;
					end
					BS_SLLI: begin
						ctrl.alu_op  = ALU_SLL;
						ctrl.imm_sel = IMM_5;
					end
					BS_ROTRI: begin
						ctrl.alu_op  = ALU_ROTR;
						ctrl.imm_sel = IMM_5;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrl.alu_op    = ALU_ADD;
				ctrl.imm_sel   = IMM_15;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op    = ALU_OR;
				ctrl.imm_sel   = IMM_15;
				ctrl.imm_ext   = EXT_ZERO;
				ctrl.reg_write = 1'b1;
			end
			OP_XORI: begin
				ctrl.alu_op    = ALU_XOR;
				ctrl.imm_sel   = IMM_15;
				ctrl.imm_ext   = EXT_ZERO;
				ctrl.reg_write = 1'b1;
			end
			OP_MOVI: begin
				ctrl.imm_sel   = IMM_20;
				ctrl.reg_write = 1'b1;
			end
			OP_LWI: begin
				ctrl.imm_sel    = IMM_15;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			OP_SWI: begin
				ctrl.imm_sel   = IMM_15;
				ctrl.mem_write = 1'b1;
			end
			OP_TY_LS: begin
				ctrl.addr_sel = ADDR_REG;
				case (ls_sub)
					LS_LW: begin
						ctrl.mem_read   = 1'b1;
						ctrl.mem_to_reg = 1'b1;
						ctrl.reg_write  = 1'b1;
					end
					LS_SW: ctrl.mem_write = 1'b1;
					default: ;
				endcase
			end
			// anything else retires as a no-op
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module datapath import cpu_pkg::*; (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire instr_t                     im_data,
	input  wire logic                       ir_load,
	input  wire logic                       pc_advance,
	input  wire logic                       execute,
	input  wire logic                       writeback,
	input  wire ctrl_t                      ctrl,
	input  wire logic [`CPU_XLEN-1:0]       dm_rdata,
	output logic      [`CPU_XLEN-1:0]       pc,
	output instr_t                          ir,
	output logic      [`CPU_DADDR_BITS-1:0] dm_addr,
	output logic      [`CPU_XLEN-1:0]       dm_wdata,
	output logic                            dm_read,
	output logic                            dm_write,
	output logic                            wb_valid,
	output logic      [`CPU_REG_ABITS-1:0]  wb_reg,
	output logic      [`CPU_XLEN-1:0]       wb_data,
	output logic                            st_valid,
	output logic      [`CPU_DADDR_BITS-1:0] st_addr,
	output logic      [`CPU_XLEN-1:0]       st_data
);

	logic [`CPU_XLEN-1:0] ra_data, rb_data, rt_data;
	logic [`CPU_XLEN-1:0] imm5, imm15_ext, imm20_ext;
	logic [`CPU_XLEN-1:0] op_b, alu_y, result;
	logic [`CPU_XLEN-1:0] addr_full;
	logic [14:0]          imm15;
	logic [19:0]          imm20;
	logic [1:0]           sv;
	logic                 rf_we;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `CPU_RESET_PC;
			ir <= '0;
		end else begin
			if (pc_advance) begin
				pc <= pc + 32'd4;
			end
			if (ir_load) begin
				ir <= im_data;
			end
		end
	end

	// immediate fields overlap the low register slots
	assign imm15 = {ir.rb, ir.fill, ir.sub};
	assign imm20 = {ir.ra, ir.rb, ir.fill, ir.sub};
	assign sv    = ir.fill[4:3];

	assign imm5      = {{(`CPU_XLEN-5){1'b0}}, ir.rb};
	assign imm15_ext = (ctrl.imm_ext == EXT_ZERO) ? {{(`CPU_XLEN-15){1'b0}}, imm15}
	                                              : {{(`CPU_XLEN-15){imm15[14]}}, imm15};
	assign imm20_ext = {{(`CPU_XLEN-20){imm20[19]}}, imm20};

	always_comb begin
		case (ctrl.imm_sel)
			IMM_5:   op_b = imm5;
			IMM_15:  op_b = imm15_ext;
			IMM_20:  op_b = imm20_ext;
			default: op_b = rb_data;
		endcase
	end

	assign addr_full = (ctrl.addr_sel == ADDR_REG) ? ra_data + (rb_data << sv)
	                                               : ra_data + (imm15_ext << 2);

	regfile u_regfile (
		.clock   (clock),
		.reset   (reset),
		.ra_addr (ir.ra),
		.rb_addr (ir.rb),
		.rt_addr (ir.rt),
		.we      (rf_we),
		.wd      (wb_data),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	alu u_alu (
		.op (ctrl.alu_op),
		.a  (ra_data),
		.b  (op_b),
		.y  (alu_y)
	);

	always_ff @(posedge clock) begin
		if (execute) begin
			result <= alu_y;
		end
	end

	assign dm_addr  = addr_full[`CPU_DADDR_BITS-1:0];
	assign dm_wdata = rt_data;
	assign dm_read  = execute && ctrl.mem_read;
	assign dm_write = execute && ctrl.mem_write;

	// load data arrives one cycle after the execute read
	assign wb_data  = ctrl.mem_to_reg ? dm_rdata : result;
	assign rf_we    = writeback && ctrl.reg_write;
	assign wb_valid = rf_we;
	assign wb_reg   = ir.rt;

	assign st_valid = dm_write;
	assign st_addr  = dm_addr;
	assign st_data  = dm_wdata;

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       load,
	input  wire logic [`CPU_IMEM_ABITS-1:0] load_addr,
	input  wire instr_t                     load_data,
	input  wire logic                       load_write,
	output logic                            wb_valid,
	output logic      [`CPU_REG_ABITS-1:0]  wb_reg,
	output logic      [`CPU_XLEN-1:0]       wb_data,
	output logic                            st_valid,
	output logic      [`CPU_DADDR_BITS-1:0] st_addr,
	output logic      [`CPU_XLEN-1:0]       st_data
);

	logic                       im_read, ir_load, pc_advance, execute, writeback;
	ctrl_t                      ctrl;
	instr_t                     ir, im_data;
	logic [`CPU_XLEN-1:0]       pc;
	logic [`CPU_IMEM_ABITS-1:0] im_addr;
	logic                       im_we;
	logic [`CPU_DADDR_BITS-1:0] dm_addr;
	logic [`CPU_XLEN-1:0]       dm_wdata, dm_rdata;
	logic                       dm_read, dm_write;

	// program load takes over the instruction memory port
	assign im_addr = load ? load_addr : pc[`CPU_IMEM_ABITS+1:2];
	assign im_we   = load && load_write;

	controller u_controller (
		.clock      (clock),
		.reset      (reset),
		.hold       (load),
		.ir         (ir),
		.im_read    (im_read),
		.ir_load    (ir_load),
		.pc_advance (pc_advance),
		.execute    (execute),
		.writeback  (writeback),
		.ctrl       (ctrl)
	);

	datapath u_datapath (
		.clock      (clock),
		.reset      (reset),
		.im_data    (im_data),
		.ir_load    (ir_load),
		.pc_advance (pc_advance),
		.execute    (execute),
		.writeback  (writeback),
		.ctrl       (ctrl),
		.dm_rdata   (dm_rdata),
		.pc         (pc),
		.ir         (ir),
		.dm_addr    (dm_addr),
		.dm_wdata   (dm_wdata),
		.dm_read    (dm_read),
		.dm_write   (dm_write),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.st_valid   (st_valid),
		.st_addr    (st_addr),
		.st_data    (st_data)
	);

	sync_mem #(.word_t(instr_t), .depth(`CPU_IMEM_WORDS)) u_imem (
		.clock (clock),
		.addr  (im_addr),
		.we    (im_we),
		.re    (im_read),
		.wdata (load_data),
		.rdata (im_data)
	);

	// word addressed with the byte offset dropped
	sync_mem #(.word_t(logic [`CPU_XLEN-1:0]), .depth(`CPU_DMEM_WORDS)) u_dmem (
		.clock (clock),
		.addr  (dm_addr[`CPU_DADDR_BITS-1:2]),
		.we    (dm_write),
		.re    (dm_read),
		.wdata (dm_wdata),
		.rdata (dm_rdata)
	);

endmodule

`default_nettype wire

// File: cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

	typedef enum logic [1:0] {EV_NONE, EV_WRITE, EV_STORE} ev_kind_e;

	typedef struct packed {
		ev_kind_e    kind;
		logic [7:0]  step;
		logic [31:0] target;
		logic [31:0] value;
	} event_t;

	logic                       clock = 1'b0;
	logic                       reset;
	logic                       load;
	logic [`CPU_IMEM_ABITS-1:0] load_addr;
	instr_t                     load_data;
	logic                       load_write;
	logic                       wb_valid;
	logic [`CPU_REG_ABITS-1:0]  wb_reg;
	logic [`CPU_XLEN-1:0]       wb_data;
	logic                       st_valid;
	logic [`CPU_DADDR_BITS-1:0] st_addr;
	logic [`CPU_XLEN-1:0]       st_data;

	instr_t prog [$];
	event_t steps [$];
	event_t exp_q [$];

	int checks       = 0;
	int mismatches   = 0;
	int event_errors = 0;
	int cycles       = 0;
	int cycle_limit  = 0;
	logic running    = 1'b0;

	cpu_top u_cpu_top (
		.clock      (clock),
		.reset      (reset),
		.load       (load),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_write (load_write),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.st_valid   (st_valid),
		.st_addr    (st_addr),
		.st_data    (st_data)
	);

	always #20 clock = ~clock;

	function automatic instr_t reg_instr(input logic [4:0] sub, input logic [4:0] rt,
	                                     input logic [4:0] ra, input logic [4:0] rb);
		reg_instr = {1'b0, OP_TY_BASE, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic instr_t imm_instr(input logic [5:0] op, input logic [4:0] rt,
	                                     input logic [4:0] ra, input logic [14:0] imm);
		imm_instr = {1'b0, op, rt, ra, imm};
	endfunction

	function automatic instr_t movi_instr(input logic [4:0] rt, input logic [19:0] imm);
		movi_instr = {1'b0, OP_MOVI, rt, imm};
	endfunction

	// sv sits in bits 9..8 above the sub-opcode
	function automatic instr_t indexed_instr(input logic [7:0] sub, input logic [4:0] rt,
	                                         input logic [4:0] ra, input logic [4:0] rb,
	                                         input logic [1:0] sv);
		indexed_instr = {1'b0, OP_TY_LS, rt, ra, rb, sv, sub};
	endfunction

	task automatic add_step(input instr_t word, input ev_kind_e kind,
	                        input logic [31:0] target, input logic [31:0] value);
		event_t e;
		e.kind   = kind;
		e.step   = prog.size();
		e.target = target;
		e.value  = value;
		prog.push_back(word);
		steps.push_back(e);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("ERR %0t %s expected 0x%h actual 0x%h", $time, name, expected, actual);
		end
	endtask

	task automatic take_event(input ev_kind_e kind, input logic [31:0] target,
	                          input logic [31:0] value);
		event_t   e;
		ev_kind_e want;
		if (exp_q.size() == 0) begin
			event_errors++;
			$display("%0t: extra %s event arrived after all expected events", $time, kind.name());
		end else begin
			e    = exp_q.pop_front();
			want = e.kind;
			if (want != kind) begin
				event_errors++;
				$display("%0t: step %0d should give a %s event but a %s event arrived",
				         $time, e.step, want.name(), kind.name());
			end else if (kind == EV_WRITE) begin
				check_value("wb_reg", e.target, target);
				check_value("wb_data", e.value, value);
			end else begin
				check_value("st_addr", e.target, target);
				check_value("st_data", e.value, value);
			end
		end
	endtask

	task automatic print_summary();
		$display("summary: %0d checks, %0d value mismatches, %0d event errors",
		         checks, mismatches, event_errors);
	endtask

	// program with hand-worked results from zeroed registers and memory
	task automatic build_table();
		// sign and zero extension of immediates
		add_step(movi_instr(5'd1, 20'h12345), EV_WRITE, 1, 32'h0001_2345);
		add_step(movi_instr(5'd2, 20'hFFFF0), EV_WRITE, 2, 32'hFFFF_FFF0);
		add_step(imm_instr(OP_ADDI, 5'd3, 5'd1, 15'h7FFF), EV_WRITE, 3, 32'h0001_2344);
		add_step(imm_instr(OP_ADDI, 5'd4, 5'd0, 15'h4000), EV_WRITE, 4, 32'hFFFF_C000);
		add_step(imm_instr(OP_ORI, 5'd5, 5'd1, 15'h7000), EV_WRITE, 5, 32'h0001_7345);
		add_step(imm_instr(OP_XORI, 5'd6, 5'd2, 15'h5555), EV_WRITE, 6, 32'hFFFF_AAA5);
		// register ops
		add_step(reg_instr(BS_ADD, 5'd7, 5'd1, 5'd2), EV_WRITE, 7, 32'h0001_2335);
		add_step(reg_instr(BS_SUB, 5'd8, 5'd1, 5'd4), EV_WRITE, 8, 32'h0001_6345);
		add_step(reg_instr(BS_AND, 5'd9, 5'd5, 5'd6), EV_WRITE, 9, 32'h0001_2205);
		add_step(reg_instr(BS_OR, 5'd10, 5'd4, 5'd1), EV_WRITE, 10, 32'hFFFF_E345);
		add_step(reg_instr(BS_XOR, 5'd11, 5'd6, 5'd3), EV_WRITE, 11, 32'hFFFE_89E1);
		// shift amount rides in the rb slot
		add_step(reg_instr(BS_SRLI, 5'd12, 5'd6, 5'd4), EV_WRITE, 12, 32'h0FFF_FAAA);
		add_step(reg_instr(BS_SLLI, 5'd13, 5'd1, 5'd8), EV_WRITE, 13, 32'h0123_4500);
		add_step(reg_instr(BS_ROTRI, 5'd14, 5'd1, 5'd4), EV_WRITE, 14, 32'h5000_1234);
		add_step(reg_instr(BS_SRLI, 5'd15, 5'd6, 5'd31), EV_WRITE, 15, 32'h0000_0001);
		add_step(reg_instr(BS_SLLI, 5'd16, 5'd6, 5'd0), EV_WRITE, 16, 32'hFFFF_AAA5);
		add_step(reg_instr(BS_ROTRI, 5'd17, 5'd6, 5'd31), EV_WRITE, 17, 32'hFFFF_554B);
		add_step(reg_instr(BS_SLLI, 5'd18, 5'd1, 5'd31), EV_WRITE, 18, 32'h8000_0000);
		add_step(reg_instr(BS_ROTRI, 5'd19, 5'd5, 5'd0), EV_WRITE, 19, 32'h0001_7345);
		// immediate offset scaled by 4
		add_step(movi_instr(5'd20, 20'h00100), EV_WRITE, 20, 32'h0000_0100);
		add_step(imm_instr(OP_SWI, 5'd11, 5'd20, 15'h0003), EV_STORE, 32'h10C, 32'hFFFE_89E1);
		add_step(imm_instr(OP_SWI, 5'd14, 5'd20, 15'h7FFE), EV_STORE, 32'h0F8, 32'h5000_1234);
		add_step(imm_instr(OP_LWI, 5'd21, 5'd20, 15'h0003), EV_WRITE, 21, 32'hFFFE_89E1);
		add_step(imm_instr(OP_LWI, 5'd22, 5'd20, 15'h7FFE), EV_WRITE, 22, 32'h5000_1234);
		// register index from base 0x100 plus 8 << sv
		add_step(movi_instr(5'd23, 20'h00008), EV_WRITE, 23, 32'h0000_0008);
		add_step(indexed_instr(LS_SW, 5'd7, 5'd20, 5'd23, 2'd0), EV_STORE, 32'h108, 32'h0001_2335);
		add_step(indexed_instr(LS_SW, 5'd8, 5'd20, 5'd23, 2'd1), EV_STORE, 32'h110, 32'h0001_6345);
		add_step(indexed_instr(LS_SW, 5'd9, 5'd20, 5'd23, 2'd2), EV_STORE, 32'h120, 32'h0001_2205);
		add_step(indexed_instr(LS_SW, 5'd10, 5'd20, 5'd23, 2'd3), EV_STORE, 32'h140, 32'hFFFF_E345);
		add_step(indexed_instr(LS_LW, 5'd24, 5'd20, 5'd23, 2'd0), EV_WRITE, 24, 32'h0001_2335);
		add_step(indexed_instr(LS_LW, 5'd25, 5'd20, 5'd23, 2'd1), EV_WRITE, 25, 32'h0001_6345);
		add_step(indexed_instr(LS_LW, 5'd26, 5'd20, 5'd23, 2'd2), EV_WRITE, 26, 32'h0001_2205);
		add_step(indexed_instr(LS_LW, 5'd27, 5'd20, 5'd23, 2'd3), EV_WRITE, 27, 32'hFFFF_E345);
		// undefined encodings retire silently
		add_step(imm_instr(6'b111111, 5'd28, 5'd1, 15'h1234), EV_NONE, 0, 0);
		add_step(reg_instr(5'b11111, 5'd28, 5'd1, 5'd2), EV_NONE, 0, 0);
		add_step(indexed_instr(8'hFF, 5'd28, 5'd20, 5'd23, 2'd0), EV_NONE, 0, 0);
		add_step(imm_instr(OP_ADDI, 5'd28, 5'd1, 15'h0001), EV_WRITE, 28, 32'h0001_2346);
	endtask

	always @(posedge clock) begin
		if (wb_valid === 1'b1) begin
			take_event(EV_WRITE, wb_reg, wb_data);
		end
		if (st_valid === 1'b1) begin
			take_event(EV_STORE, st_addr, st_data);
		end
	end

	initial begin : watchdog
		wait (running);
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d expected events never arrived",
		         cycles, exp_q.size());
		print_summary();
		$display("Test failures found");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		load       = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		load_write = 1'b0;
		build_table();
		cycle_limit = prog.size() * (int'(WRITEBACK) + 1) + 20;

		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// core sits idle while the program goes in
		load = 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			load_addr  = i;
			load_data  = prog[i];
			load_write = 1'b1;
			if (steps[i].kind != EV_NONE) begin
				exp_q.push_back(steps[i]);
			end
			@(negedge clock);
		end
		load_write = 1'b0;
		load       = 1'b0;
		running    = 1'b1;

		while (exp_q.size() != 0) begin
			@(posedge clock);
		end
		// two more instruction slots to catch stray events
		repeat (8) @(posedge clock);

		print_summary();
		if (mismatches == 0 && event_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: multicycle_cpu.f
+incdir+.
cpu_pkg.sv
sync_mem.sv
regfile.sv
alu.sv
controller.sv
datapath.sv
cpu_top.sv
cpu_tb.sv

// File: Bender.yml
package:
  name: multicycle_cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - sync_mem.sv
      - regfile.sv
      - alu.sv
      - controller.sv
      - datapath.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_tb.sv
